/* dv/floor_logic_tb.sv */
// Testbench for the elevator request-side top level
// Clock, reset, car motion model, reference functions, scoreboard,
// directed and random tests, watchdog

`timescale 1ns/1ns
`include "elevator_defines.svh"

module floor_logic_tb;

    //////////////////////////////////////////////////////////////////////
    // Timing and budget
    //////////////////////////////////////////////////////////////////////

    localparam int STEP_CYCLES  = 8;
    localparam int RESET_CYCLES = 10;
    // Requests per test, in test order
    localparam int REQUEST_BUDGET = 2 + 5 + 1 + 1 + 1 + 16;
    localparam int TIMEOUT_CYCLES = 2 * REQUEST_BUDGET * `NUM_FLOORS * STEP_CYCLES;

    logic                       clock;
    logic                       reset_n;
    floor_pkg::floor_mask_t     floor_call_buttons;
    floor_pkg::floor_mask_t     panel_buttons;
    logic                       door_open_btn;
    logic                       door_close_btn;
    logic                       emergency_btn;
    logic                       power_switch;
    control_pkg::car_status_t   car_status;
    control_pkg::dispatch_cmd_t dispatch_cmd;
    floor_pkg::floor_mask_t     call_button_lights;
    floor_pkg::floor_mask_t     panel_button_lights;
    logic                       door_open_allowed;
    logic                       door_close_allowed;

    // Scoreboard state
    floor_pkg::floor_t expected_floors[$];
    int                pending_lamp;
    logic              activate_prev;
    floor_pkg::floor_mask_t panel_prev;
    floor_pkg::floor_mask_t call_prev;
    int                push_count;
    int                trip_count;
    int                error_count;
    int                test_count;
    int                test_ok_count;
    int                errors_at_start;
    int                pushes_at_start;
    int                trips_at_start;

    // Car model state
    control_pkg::dispatch_cmd_t cmd_seen;
    floor_pkg::direction_t      car_dir;
    int                         step_count;

    integer      seed;
    logic [31:0] rand_word;
    int          cur;
    int          code;

    floor_logic_top DUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_status          (car_status),
        .dispatch_cmd        (dispatch_cmd),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Lowest new panel press, else lowest new call press, else -1
    function automatic int expected_winner(
        input floor_pkg::floor_mask_t panel_lamps,
        input floor_pkg::floor_mask_t call_lamps,
        input floor_pkg::floor_mask_t panel_pressed,
        input floor_pkg::floor_mask_t call_pressed,
        input floor_pkg::floor_t      current,
        input logic                   moving,
        input logic                   enabled
    );
        floor_pkg::floor_mask_t free_floors;
        int i;
        if (!enabled) begin
            return -1;
        end
        free_floors = ~(panel_lamps | call_lamps);
        if (!moving) begin
            free_floors[current] = 1'b0;
        end
        for (i = 0; i < `NUM_FLOORS; i++) begin
            if (panel_pressed[i] && free_floors[i]) begin
                return i;
            end
        end
        for (i = 0; i < `NUM_FLOORS; i++) begin
            if (call_pressed[i] && free_floors[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic floor_pkg::direction_t expected_direction(
        input floor_pkg::floor_t target,
        input floor_pkg::floor_t current
    );
        if (target > current) begin
            return floor_pkg::DIR_UP;
        end
        return floor_pkg::DIR_DOWN;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Scoreboard, sampled on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin : scoreboard
        int winner;
        floor_pkg::floor_t want;
        floor_pkg::floor_mask_t lit_now;
        if (!reset_n) begin
            pending_lamp  = -1;
            activate_prev = 1'b0;
            panel_prev    = '0;
            call_prev     = '0;
        end else begin
            // Only the floor pushed on the previous edge may go from dark to lit
            lit_now = (panel_button_lights & ~panel_prev) | (call_button_lights & ~call_prev);
            check_value("newly lit lamps", int'(lit_now),
                        (pending_lamp >= 0) ? (1 << pending_lamp) : 0);
            panel_prev = panel_button_lights;
            call_prev  = call_button_lights;
            if (dispatch_cmd.activate && !activate_prev) begin
                trip_count++;
                if (expected_floors.size() == 0) begin
                    error_count++;
                    $display("Error at %0t ns: activate rose with no request pending", $time);
                end else begin
                    want = expected_floors.pop_front();
                    check_value("dispatch_cmd.target_floor",
                                int'(dispatch_cmd.target_floor), int'(want));
                    check_value("dispatch_cmd.direction", int'(dispatch_cmd.direction),
                                int'(expected_direction(want, car_status.current_floor)));
                end
            end
            activate_prev = dispatch_cmd.activate;
            winner = expected_winner(panel_button_lights, call_button_lights,
                                     panel_buttons, floor_call_buttons,
                                     car_status.current_floor, car_status.moving,
                                     power_switch && !emergency_btn);
            pending_lamp = winner;
            if (winner >= 0) begin
                expected_floors.push_back(floor_pkg::floor_t'(winner));
                push_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Car model, one floor every STEP_CYCLES while moving
    //////////////////////////////////////////////////////////////////////

    initial begin : car_model
        car_status = '0;
        step_count = 0;
        forever begin
            @(posedge clock);
            cmd_seen = dispatch_cmd;
            @(negedge clock);
            if (!car_status.moving) begin
                if (cmd_seen.activate) begin
                    car_status.moving = 1'b1;
                    car_dir           = cmd_seen.direction;
                    step_count        = 0;
                end
            end else begin
                step_count++;
                if (step_count == STEP_CYCLES) begin
                    step_count = 0;
                    if (car_dir == floor_pkg::DIR_UP) begin
                        car_status.current_floor = car_status.current_floor + 1'b1;
                    end else begin
                        car_status.current_floor = car_status.current_floor - 1'b1;
                    end
                    if (car_status.current_floor == cmd_seen.target_floor) begin
                        car_status.moving = 1'b0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers, all entered right after a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    task automatic press_button(input logic on_panel, input int floor_code, input int hold);
        if (on_panel) begin
            panel_buttons[floor_code] = 1'b1;
        end else begin
            floor_call_buttons[floor_code] = 1'b1;
        end
        wait_cycles(hold);
        panel_buttons[floor_code]      = 1'b0;
        floor_call_buttons[floor_code] = 1'b0;
    endtask

    task automatic wait_moving();
        while (!car_status.moving) begin
            wait_cycles(1);
        end
    endtask

    // Every request served, car parked and all lamps dark
    task automatic wait_settled();
        wait_cycles(1);
        while (expected_floors.size() != 0 || car_status.moving || dispatch_cmd.activate
               || panel_button_lights != '0 || call_button_lights != '0) begin
            wait_cycles(1);
        end
    endtask

    task automatic finish_test(input string name);
        check_value("trips in test", trip_count - trips_at_start, push_count - pushes_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            test_ok_count++;
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
        pushes_at_start = push_count;
        trips_at_start  = trip_count;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin : tests
        seed               = 32'h73ea;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        push_count         = 0;
        trip_count         = 0;
        error_count        = 0;
        test_count         = 0;
        test_ok_count      = 0;
        errors_at_start    = 0;
        pushes_at_start    = 0;
        trips_at_start     = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        check_value("panel_button_lights", int'(panel_button_lights), 0);
        check_value("call_button_lights", int'(call_button_lights), 0);
        check_value("dispatch_cmd.activate", int'(dispatch_cmd.activate), 0);
        check_value("door_open_allowed", int'(door_open_allowed), 0);
        check_value("door_close_allowed", int'(door_close_allowed), 0);
        finish_test("reset state");

        press_button(1'b1, 5, 1);
        check_value("panel_button_lights[5]", int'(panel_button_lights[5]), 1);
        wait_settled();
        check_value("lamps of floor 6", int'(panel_button_lights[5] | call_button_lights[5]), 0);
        press_button(1'b0, 2, 1);
        check_value("call_button_lights[2]", int'(call_button_lights[2]), 1);
        wait_settled();
        check_value("lamps of floor 3", int'(panel_button_lights[2] | call_button_lights[2]), 0);
        finish_test("single panel and call requests");

        // Presses during travel queue up behind the first trip
        press_button(1'b1, 10, 1);
        wait_moving();
        press_button(1'b1, 6, 1);
        wait_cycles(3);
        press_button(1'b0, 1, 2);
        wait_cycles(5);
        press_button(1'b1, 3, 1);
        press_button(1'b0, 8, 1);
        wait_settled();
        check_value("requests accepted", push_count - pushes_at_start, 5);
        finish_test("press order during travel");

        cur = int'(car_status.current_floor);
        press_button(1'b1, cur, 4);
        press_button(1'b0, cur, 4);
        check_value("panel_button_lights", int'(panel_button_lights), 0);
        check_value("call_button_lights", int'(call_button_lights), 0);
        code = (cur + 5) % `NUM_FLOORS;
        press_button(1'b1, code, 1);
        wait_cycles(3);
        press_button(1'b0, code, 2);
        press_button(1'b1, code, 2);
        wait_settled();
        check_value("requests accepted", push_count - pushes_at_start, 1);
        finish_test("current floor and lit floor ignored");

        emergency_btn = 1'b1;
        press_button(1'b1, 7, 4);
        check_value("panel_button_lights", int'(panel_button_lights), 0);
        emergency_btn = 1'b0;
        power_switch  = 1'b0;
        press_button(1'b0, 7, 4);
        check_value("call_button_lights", int'(call_button_lights), 0);
        power_switch = 1'b1;
        // Queued request waits out the emergency
        cur  = int'(car_status.current_floor);
        code = (cur + 4) % `NUM_FLOORS;
        press_button(1'b1, code, 1);
        emergency_btn = 1'b1;
        repeat (20) begin
            wait_cycles(1);
            check_value("dispatch_cmd.activate", int'(dispatch_cmd.activate), 0);
        end
        emergency_btn = 1'b0;
        wait_settled();
        check_value("requests accepted", push_count - pushes_at_start, 1);
        finish_test("emergency and power off");

        door_open_btn = 1'b1;
        wait_cycles(1);
        check_value("door_open_allowed", int'(door_open_allowed), 1);
        check_value("door_close_allowed", int'(door_close_allowed), 0);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        wait_cycles(1);
        check_value("door_open_allowed", int'(door_open_allowed), 0);
        check_value("door_close_allowed", int'(door_close_allowed), 1);
        door_close_btn = 1'b0;
        code = (int'(car_status.current_floor) < 5) ? 10 : 0;
        press_button(1'b0, code, 1);
        wait_moving();
        door_open_btn  = 1'b1;
        door_close_btn = 1'b1;
        wait_cycles(2);
        check_value("door_open_allowed", int'(door_open_allowed), 0);
        check_value("door_close_allowed", int'(door_close_allowed), 0);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        wait_settled();
        finish_test("door permissions");

        // Sparse random presses on both banks
        repeat (80) begin
            panel_buttons      = '0;
            floor_call_buttons = '0;
            rand_word = $random(seed);
            if (rand_word[2:0] == 3'd0) begin
                code = int'(rand_word[15:8]) % `NUM_FLOORS;
                if (rand_word[3]) begin
                    panel_buttons[code] = 1'b1;
                end else begin
                    floor_call_buttons[code] = 1'b1;
                end
            end
            wait_cycles(1);
        end
        panel_buttons      = '0;
        floor_call_buttons = '0;
        wait_settled();
        finish_test("random traffic");

        $display("%0d tests, %0d ok, %0d check errors", test_count, test_ok_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clock);
        $display("Watchdog: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* hdl/car_dispatcher.sv */
// Car dispatcher
// Pops targets, drives activate and direction, reports arrival,
// registers the door permissions

`timescale 1ns/1ns

module car_dispatcher (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        power_switch,
    input  logic                        emergency_btn,
    input  logic                        door_open_btn,
    input  logic                        door_close_btn,
    input  control_pkg::car_status_t    car_status,
    input  logic                        queue_empty,
    input  floor_pkg::floor_t           head_floor,
    output logic                        pop,
    output control_pkg::dispatch_cmd_t  dispatch_cmd,
    output logic                        arrived,
    output floor_pkg::floor_t           arrived_floor,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed
);

    control_pkg::dispatch_state_t state;
    floor_pkg::floor_t            target;
    floor_pkg::direction_t        direction;
    logic                         enabled;
    logic                         at_target;
    logic                         activate;

    assign enabled   = power_switch && !emergency_btn;
    assign at_target = (car_status.current_floor == target);
    assign direction = (target > car_status.current_floor) ?
                       floor_pkg::DIR_UP : floor_pkg::DIR_DOWN;

    // Held through DEPART until the car reports motion
    assign activate = (state == control_pkg::DISP_DEPART) && !at_target && enabled;

    always_comb begin
        dispatch_cmd.target_floor = target;
        dispatch_cmd.direction    = direction;
        dispatch_cmd.activate     = activate;
    end

    // Target stays put from pop until the arrival pulse is gone
    assign arrived_floor = target;

    //////////////////////////////////////////////////////////////////////
    // Dispatch FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state   <= control_pkg::DISP_IDLE;
            pop     <= 1'b0;
            arrived <= 1'b0;
        end else begin
            pop     <= 1'b0;
            arrived <= 1'b0;
            case (state)
                control_pkg::DISP_IDLE: begin
                    // One cycle of pop, then the head is taken as target
                    if (pop) begin
                        state <= control_pkg::DISP_DEPART;
                    end else if (!queue_empty) begin
                        pop <= 1'b1;
                    end
                end
                control_pkg::DISP_DEPART: begin
                    if (car_status.moving) begin
                        state <= control_pkg::DISP_TRAVEL;
                    end else if (at_target) begin
                        arrived <= 1'b1;
                        state   <= control_pkg::DISP_IDLE;
                    end
                end
                control_pkg::DISP_TRAVEL: begin
                    if (!car_status.moving) begin
                        if (at_target) begin
                            arrived <= 1'b1;
                            state   <= control_pkg::DISP_IDLE;
                        end else begin
                            state <= control_pkg::DISP_DEPART;
                        end
                    end
                end
                default: state <= control_pkg::DISP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == control_pkg::DISP_IDLE && pop) begin
            target <= head_floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Door permissions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && !car_status.moving && power_switch;
            door_close_allowed <= door_close_btn && !car_status.moving && power_switch;
        end
    end

    // Car must be stopped whenever a new trip is requested
    a_activate_from_rest: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(activate) |-> !car_status.moving);

endmodule

/* hdl/control_pkg.sv */
// Control types shared between the car and the dispatcher
// Car status struct, dispatch command struct, dispatcher FSM states

package control_pkg;

    //////////////////////////////////////////////////////////////////////
    // Car interface
    //////////////////////////////////////////////////////////////////////

    // Reported by the car every cycle
    typedef struct packed {
        floor_pkg::floor_t current_floor;
        logic              moving;
    } car_status_t;

    // Command toward the car
    typedef struct packed {
        floor_pkg::floor_t     target_floor;
        floor_pkg::direction_t direction;
        logic                  activate;
    } dispatch_cmd_t;

    //////////////////////////////////////////////////////////////////////
    // Dispatcher FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        DISP_IDLE   = 2'd0,
        DISP_DEPART = 2'd1,
        DISP_TRAVEL = 2'd2
    } dispatch_state_t;

endpackage

/* hdl/elevator_defines.svh */
// Elevator request-side sizing macros
// Floor count, floor code width, request queue depth and pointer width

`ifndef ELEVATOR_DEFINES_SVH
`define ELEVATOR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Building geometry
//////////////////////////////////////////////////////////////////////

// Floors served by the car
`define NUM_FLOORS 11

// Floor 1 is code 0 and floor 11 is code 10
`define FLOOR_W 4

//////////////////////////////////////////////////////////////////////
// Request queue sizing
//////////////////////////////////////////////////////////////////////

`define QUEUE_DEPTH 16
`define QUEUE_PTR_W 4

`endif

/* hdl/floor_logic_top.sv */
// Elevator request-side top level
// Button latch, request FIFO and car dispatcher

`timescale 1ns/1ns

module floor_logic_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  floor_pkg::floor_mask_t      floor_call_buttons,
    input  floor_pkg::floor_mask_t      panel_buttons,
    input  logic                        door_open_btn,
    input  logic                        door_close_btn,
    input  logic                        emergency_btn,
    input  logic                        power_switch,
    input  control_pkg::car_status_t    car_status,
    output control_pkg::dispatch_cmd_t  dispatch_cmd,
    output floor_pkg::floor_mask_t      call_button_lights,
    output floor_pkg::floor_mask_t      panel_button_lights,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed
);

    logic              request_valid;
    floor_pkg::floor_t request_floor;
    logic              queue_empty;
    floor_pkg::floor_t head_floor;
    logic              pop;
    logic              arrived;
    floor_pkg::floor_t arrived_floor;

    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_status          (car_status),
        .arrived             (arrived),
        .arrived_floor       (arrived_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .request_valid       (request_valid),
        .request_floor       (request_floor)
    );

    request_queue u_request_queue (
        .clock         (clock),
        .reset_n       (reset_n),
        .request_valid (request_valid),
        .request_floor (request_floor),
        .pop           (pop),
        .queue_empty   (queue_empty),
        .head_floor    (head_floor)
    );

    car_dispatcher u_car_dispatcher (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .car_status         (car_status),
        .queue_empty        (queue_empty),
        .head_floor         (head_floor),
        .pop                (pop),
        .dispatch_cmd       (dispatch_cmd),
        .arrived            (arrived),
        .arrived_floor      (arrived_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* hdl/floor_pkg.sv */
// Floor-related types
// Floor code, per-floor button and lamp mask, travel direction

`include "elevator_defines.svh"

package floor_pkg;

    //////////////////////////////////////////////////////////////////////
    // Floor encoding
    //////////////////////////////////////////////////////////////////////

    // Binary floor code, floor 1 maps to zero
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Travel direction
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

/* hdl/request_latch.sv */
// Hall and cab button sampling
// Lamp banks, fixed-priority acceptance, one push per new floor

`timescale 1ns/1ns
`include "elevator_defines.svh"

module request_latch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  floor_pkg::floor_mask_t    floor_call_buttons,
    input  floor_pkg::floor_mask_t    panel_buttons,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  control_pkg::car_status_t  car_status,
    input  logic                      arrived,
    input  floor_pkg::floor_t         arrived_floor,
    output floor_pkg::floor_mask_t    call_button_lights,
    output floor_pkg::floor_mask_t    panel_button_lights,
    output logic                      request_valid,
    output floor_pkg::floor_t         request_floor
);

    logic                   enabled;
    floor_pkg::floor_mask_t stop_mask;
    floor_pkg::floor_mask_t clear_mask;
    floor_pkg::floor_mask_t new_panel;
    floor_pkg::floor_mask_t new_call;
    floor_pkg::floor_mask_t panel_set;
    floor_pkg::floor_mask_t call_set;
    logic                   panel_hit;
    logic                   call_hit;
    floor_pkg::floor_t      panel_floor;
    floor_pkg::floor_t      call_floor;
    floor_pkg::floor_mask_t lamps;

    assign enabled = power_switch && !emergency_btn;

    // Floor the car is parked at, and floor being served
    always_comb begin
        stop_mask  = '0;
        clear_mask = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!car_status.moving && car_status.current_floor == floor_pkg::floor_t'(i)) begin
                stop_mask[i] = 1'b1;
            end
            if (arrived && arrived_floor == floor_pkg::floor_t'(i)) begin
                clear_mask[i] = 1'b1;
            end
        end
    end

    // A floor is new only while both of its lamps are dark
    assign new_panel = enabled ?
        (panel_buttons & ~stop_mask & ~panel_button_lights & ~call_button_lights) : '0;
    assign new_call = enabled ?
        (floor_call_buttons & ~stop_mask & ~panel_button_lights & ~call_button_lights) : '0;

    // Lowest floor wins, scanned top down so the last hit stands
    always_comb begin
        panel_hit   = 1'b0;
        call_hit    = 1'b0;
        panel_floor = '0;
        call_floor  = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (new_panel[i]) begin
                panel_hit   = 1'b1;
                panel_floor = floor_pkg::floor_t'(i);
            end
            if (new_call[i]) begin
                call_hit   = 1'b1;
                call_floor = floor_pkg::floor_t'(i);
            end
        end
    end

    // Cab panel beats hall call
    assign request_valid = panel_hit || call_hit;
    assign request_floor = panel_hit ? panel_floor : call_floor;
    assign panel_set     = panel_hit ? (floor_pkg::floor_mask_t'(1) << panel_floor) : '0;
    assign call_set      = (!panel_hit && call_hit) ?
                           (floor_pkg::floor_mask_t'(1) << call_floor) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= (call_button_lights | call_set) & ~clear_mask;
            panel_button_lights <= (panel_button_lights | panel_set) & ~clear_mask;
        end
    end

    // Floors with at least one lamp lit
    assign lamps = call_button_lights | panel_button_lights;

    // Pushed floor was dark and is the only floor lit on the next cycle
    a_winner_was_dark: assert property (@(posedge clock) disable iff (!reset_n)
        request_valid |=> (lamps & ~$past(lamps))
                          == (floor_pkg::floor_mask_t'(1) << $past(request_floor)));

endmodule

/* hdl/request_queue.sv */
// Request FIFO
// Circular buffer of accepted floors in press order

`timescale 1ns/1ns
`include "elevator_defines.svh"

module request_queue #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              request_valid,
    input  floor_pkg::floor_t request_floor,
    input  logic              pop,
    output logic              queue_empty,
    output floor_pkg::floor_t head_floor
);

    typedef logic [`QUEUE_PTR_W-1:0] ptr_t;
    typedef logic [`QUEUE_PTR_W:0]   count_t;

    localparam ptr_t   LAST_PTR   = ptr_t'(DEPTH - 1);
    localparam count_t FULL_COUNT = count_t'(DEPTH);

    floor_pkg::floor_t mem [DEPTH];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    count_t            count;

    // Pointer wrap also handles depths that are not a power of two
    function automatic ptr_t ptr_next(input ptr_t ptr);
        ptr_next = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (request_valid) begin
            mem[wr_ptr] <= request_floor;
        end
    end

    assign head_floor  = mem[rd_ptr];
    assign queue_empty = (count == '0);

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (request_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({request_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Latch never pushes a lit floor, so a full queue means a lamp bug
    a_no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
        request_valid |-> count != FULL_COUNT);

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> count != '0);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the elevator request-side testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module floor_logic_tb \
    -f verilog.f \
    -Mdir obj_dir \
    -o floor_logic_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/floor_logic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* verilog.f */
+incdir+hdl
hdl/floor_pkg.sv
hdl/control_pkg.sv
hdl/request_latch.sv
hdl/request_queue.sv
hdl/car_dispatcher.sv
hdl/floor_logic_top.sv
dv/floor_logic_tb.sv
